//--- all.f
logic/rv_exec_pkg.sv
logic/insn_decode.sv
logic/alu.sv
logic/branch_unit.sv
logic/result_stage.sv
logic/apb_exec_regs.sv
logic/exec_top.sv
testbench/tb_exec_top.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import rv_exec_pkg::*; (
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    input  logic [31:0] imm,
    input  logic        alu_src_imm,
    input  alu_op_e     alu_op,
    output logic [31:0] alu_result
);

    logic [31:0] op_b;
    logic [4:0]  shamt;

    assign op_b  = alu_src_imm ? imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = rs1_val + op_b;
            ALU_SUB:  alu_result = rs1_val - op_b;
            ALU_SLL:  alu_result = rs1_val << shamt;
            ALU_SLT:  alu_result = {31'd0, $signed(rs1_val) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'd0, rs1_val < op_b};
            ALU_XOR:  alu_result = rs1_val ^ op_b;
            ALU_SRL:  alu_result = rs1_val >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  alu_result = $unsigned($signed(rs1_val) >>> shamt);
            ALU_OR:   alu_result = rs1_val | op_b;
            ALU_AND:  alu_result = rs1_val & op_b;
            default:  alu_result = 32'd0;
        endcase
    end

endmodule

//--- logic/apb_exec_regs.sv
`timescale 1ns/1ps

module apb_exec_regs import rv_exec_pkg::*; #(
    parameter int APB_ADDR_WIDTH = 12
) (
    input  logic                      pclk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic [31:0]               pc,
    output logic [31:0]               rs1_val,
    output logic [31:0]               rs2_val,
    output logic [31:0]               insn,
    output logic                      launch,
    input  logic [31:0]               rd_value,
    input  logic [31:0]               next_pc_q,
    input  logic [31:0]               status
);

    localparam logic [APB_ADDR_WIDTH-1:0] A_PC      = APB_ADDR_WIDTH'(REG_PC);
    localparam logic [APB_ADDR_WIDTH-1:0] A_RS1     = APB_ADDR_WIDTH'(REG_RS1);
    localparam logic [APB_ADDR_WIDTH-1:0] A_RS2     = APB_ADDR_WIDTH'(REG_RS2);
    localparam logic [APB_ADDR_WIDTH-1:0] A_INSN    = APB_ADDR_WIDTH'(REG_INSN);
    localparam logic [APB_ADDR_WIDTH-1:0] A_RD      = APB_ADDR_WIDTH'(REG_RD);
    localparam logic [APB_ADDR_WIDTH-1:0] A_NEXT_PC = APB_ADDR_WIDTH'(REG_NEXT_PC);
    localparam logic [APB_ADDR_WIDTH-1:0] A_STATUS  = APB_ADDR_WIDTH'(REG_STATUS);

    logic [31:0] rdata;
    logic        mapped;
    logic        read_only;
    logic        access;
    logic        unaligned;
    logic        bad;
    logic        wr_en;

    // ========================================================================
    // Address decode and read-back
    // ========================================================================
    always_comb begin
        rdata     = 32'd0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr)
            A_PC:      rdata = pc;
            A_RS1:     rdata = rs1_val;
            A_RS2:     rdata = rs2_val;
            A_INSN:    rdata = insn;
            A_RD:      begin rdata = rd_value;  read_only = 1'b1; end
            A_NEXT_PC: begin rdata = next_pc_q; read_only = 1'b1; end
            A_STATUS:  begin rdata = status;    read_only = 1'b1; end
            default:   mapped = 1'b0;
        endcase
    end

    assign access    = psel & penable;
    assign unaligned = |paddr[1:0];
    assign bad       = unaligned | ~mapped | (pwrite & read_only);
    assign wr_en     = access & pwrite & ~bad;

    assign pready  = 1'b1;
    assign pslverr = access & bad;
    assign prdata  = (psel & ~pwrite & ~bad) ? rdata : 32'd0;

    // ========================================================================
    // Operand registers and launch
    // ========================================================================
    always_ff @(posedge pclk) begin
        if (rst) begin
            pc      <= 32'd0;
            rs1_val <= 32'd0;
            rs2_val <= 32'd0;
            insn    <= 32'd0;
            launch  <= 1'b0;
        end else begin
            launch <= wr_en && (paddr == A_INSN);
            if (wr_en) begin
                case (paddr)
                    A_PC:    pc      <= pwdata;
                    A_RS1:   rs1_val <= pwdata;
                    A_RS2:   rs2_val <= pwdata;
                    A_INSN:  insn    <= pwdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import rv_exec_pkg::*; (
    input  logic [31:0] pc,
    input  logic [31:0] imm,
    input  logic [31:0] alu_result,
    input  br_op_e      br_op,
    output logic [31:0] next_pc,
    output logic [31:0] pc_plus4,
    output logic        br_taken
);

    logic [31:0] target;
    logic        res_zero;

    assign pc_plus4 = pc + 32'd4;
    assign target   = pc + imm;
    assign res_zero = (alu_result == 32'd0);

    // ALU already did the compare, SUB for equality and SLT/SLTU for order
    always_comb begin
        case (br_op)
            BR_BEQ:  br_taken = res_zero;
            BR_BNE:  br_taken = !res_zero;
            BR_BLT:  br_taken = !res_zero;
            BR_BLTU: br_taken = !res_zero;
            BR_BGE:  br_taken = res_zero;
            BR_BGEU: br_taken = res_zero;
            BR_JAL:  br_taken = 1'b1;
            BR_JALR: br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase

        if (br_op == BR_JALR) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (br_taken) begin
            next_pc = target;
        end else begin
            next_pc = pc_plus4;
        end
    end

endmodule

//--- logic/exec_top.sv
`timescale 1ns/1ps

module exec_top import rv_exec_pkg::*; #(
    parameter int APB_ADDR_WIDTH = 12
) (
    input  logic                      pclk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] insn;
    logic        launch;
    alu_op_e     alu_op;
    logic        alu_src_imm;
    logic [31:0] imm;
    br_op_e      br_op;
    wb_sel_e     wb_sel;
    logic        rd_write;
    logic        illegal;
    logic [31:0] alu_result;
    logic [31:0] next_pc;
    logic [31:0] pc_plus4;
    logic        br_taken;
    logic [31:0] rd_value;
    logic [31:0] next_pc_q;
    logic [31:0] status;

    apb_exec_regs #(
        .APB_ADDR_WIDTH(APB_ADDR_WIDTH)
    ) u_regs (
        .pclk(pclk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val), .insn(insn),
        .launch(launch),
        .rd_value(rd_value), .next_pc_q(next_pc_q), .status(status)
    );

    // Decode
    insn_decode u_decode (
        .insn(insn), .alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm(imm),
        .br_op(br_op), .wb_sel(wb_sel), .rd_write(rd_write), .illegal(illegal)
    );

    // Execute
    alu u_alu (
        .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm),
        .alu_src_imm(alu_src_imm), .alu_op(alu_op), .alu_result(alu_result)
    );

    branch_unit u_branch (
        .pc(pc), .imm(imm), .alu_result(alu_result), .br_op(br_op),
        .next_pc(next_pc), .pc_plus4(pc_plus4), .br_taken(br_taken)
    );

    // Result
    result_stage u_result (
        .pclk(pclk), .rst(rst), .launch(launch), .wb_sel(wb_sel),
        .alu_result(alu_result), .pc_plus4(pc_plus4), .imm(imm), .pc(pc),
        .next_pc(next_pc), .br_taken(br_taken), .illegal(illegal),
        .rd_write(rd_write),
        .rd_value(rd_value), .next_pc_q(next_pc_q), .status(status)
    );

endmodule

//--- logic/insn_decode.sv
`timescale 1ns/1ps

module insn_decode import rv_exec_pkg::*; (
    input  logic [31:0] insn,
    output alu_op_e     alu_op,
    output logic        alu_src_imm,
    output logic [31:0] imm,
    output br_op_e      br_op,
    output wb_sel_e     wb_sel,
    output logic        rd_write,
    output logic        illegal
);

    insn_u       w;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // funct3 to ALU operation, alt selects SUB / SRA
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign w = insn;

    assign imm_i = {{20{w.i.imm[11]}}, w.i.imm};
    assign imm_b = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    assign imm_u = {w.u.imm, 12'd0};
    assign imm_j = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        imm         = 32'd0;
        br_op       = BR_NONE;
        wb_sel      = WB_ALU;
        rd_write    = 1'b0;
        illegal     = 1'b0;

        case (w.r.opcode)
            OPC_OP: begin
                rd_write = 1'b1;
                alu_op   = arith_op(w.r.funct3, w.r.funct7[5]);
                // Only SUB and SRA use the alternate funct7
                if (w.r.funct7 != 7'b0000000 &&
                    !(w.r.funct7 == 7'b0100000 &&
                      (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101))) begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                rd_write    = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_i;
                alu_op      = arith_op(w.r.funct3, w.r.funct3 == 3'b101 && w.r.funct7[5]);
                if (w.r.funct3 == 3'b001 && w.r.funct7 != 7'b0000000) begin
                    illegal = 1'b1;
                end
                if (w.r.funct3 == 3'b101 && w.r.funct7 != 7'b0000000 &&
                    w.r.funct7 != 7'b0100000) begin
                    illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                rd_write = 1'b1;
                imm      = imm_u;
                wb_sel   = WB_IMM;
            end
            OPC_AUIPC: begin
                rd_write = 1'b1;
                imm      = imm_u;
                wb_sel   = WB_PCIMM;
            end
            OPC_JAL: begin
                rd_write = 1'b1;
                imm      = imm_j;
                br_op    = BR_JAL;
                wb_sel   = WB_PC4;
            end
            OPC_JALR: begin
                rd_write    = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_i;
                br_op       = BR_JALR;
                wb_sel      = WB_PC4;
                illegal     = (w.i.funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (w.b.funct3)
                    3'b000: begin br_op = BR_BEQ;  alu_op = ALU_SUB;  end
                    3'b001: begin br_op = BR_BNE;  alu_op = ALU_SUB;  end
                    3'b100: begin br_op = BR_BLT;  alu_op = ALU_SLT;  end
                    3'b101: begin br_op = BR_BGE;  alu_op = ALU_SLT;  end
                    3'b110: begin br_op = BR_BLTU; alu_op = ALU_SLTU; end
                    3'b111: begin br_op = BR_BGEU; alu_op = ALU_SLTU; end
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        // Illegal words neither write nor redirect
        if (illegal) begin
            rd_write = 1'b0;
            br_op    = BR_NONE;
        end
    end

endmodule

//--- logic/result_stage.sv
`timescale 1ns/1ps

module result_stage import rv_exec_pkg::*; (
    input  logic        pclk,
    input  logic        rst,
    input  logic        launch,
    input  wb_sel_e     wb_sel,
    input  logic [31:0] alu_result,
    input  logic [31:0] pc_plus4,
    input  logic [31:0] imm,
    input  logic [31:0] pc,
    input  logic [31:0] next_pc,
    input  logic        br_taken,
    input  logic        illegal,
    input  logic        rd_write,
    output logic [31:0] rd_value,
    output logic [31:0] next_pc_q,
    output logic [31:0] status
);

    logic [31:0] wb_value;
    logic        valid_q;
    logic        taken_q;
    logic        illegal_q;
    logic        rd_write_q;

    always_comb begin
        case (wb_sel)
            WB_PC4:   wb_value = pc_plus4;
            WB_IMM:   wb_value = imm;
            WB_PCIMM: wb_value = pc + imm;
            default:  wb_value = alu_result;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            rd_value   <= 32'd0;
            next_pc_q  <= 32'd0;
            valid_q    <= 1'b0;
            taken_q    <= 1'b0;
            illegal_q  <= 1'b0;
            rd_write_q <= 1'b0;
        end else if (launch) begin
            rd_value   <= (rd_write && !illegal) ? wb_value : 32'd0;
            next_pc_q  <= next_pc;
            valid_q    <= 1'b1;
            taken_q    <= br_taken;
            illegal_q  <= illegal;
            rd_write_q <= rd_write;
        end
    end

    // Valid drops while a new instruction is in flight
    always_comb begin
        status              = 32'd0;
        status[ST_VALID]    = valid_q & ~launch;
        status[ST_TAKEN]    = taken_q;
        status[ST_ILLEGAL]  = illegal_q;
        status[ST_RD_WRITE] = rd_write_q;
    end

endmodule

//--- logic/rv_exec_pkg.sv
package rv_exec_pkg;

    // ========================================================================
    // RV32I major opcodes
    // ========================================================================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Nine codes, so four bits
    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_PC4, WB_IMM, WB_PCIMM
    } wb_sel_e;

    // ========================================================================
    // Instruction formats
    // ========================================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } insn_u;

    // ========================================================================
    // Register map (byte offsets) and status bits
    // ========================================================================
    localparam int unsigned REG_PC      = 'h00;
    localparam int unsigned REG_RS1     = 'h04;
    localparam int unsigned REG_RS2     = 'h08;
    localparam int unsigned REG_INSN    = 'h0C;
    localparam int unsigned REG_RD      = 'h10;
    localparam int unsigned REG_NEXT_PC = 'h14;
    localparam int unsigned REG_STATUS  = 'h18;

    localparam int ST_VALID    = 0;
    localparam int ST_TAKEN    = 1;
    localparam int ST_ILLEGAL  = 2;
    localparam int ST_RD_WRITE = 3;

endpackage

//--- testbench/exec_patterns.hex
// pc rs1 rs2 insn, then expected rd next_pc status
// status bits: 0 valid, 1 taken, 2 illegal, 3 rd_write
00000100 00000005 00000007 003100B3 0000000C 00000104 00000009
00000200 00000003 00000005 403100B3 FFFFFFFE 00000204 00000009
00000300 80000000 00000004 403150B3 F8000000 00000304 00000009
00000400 FFFFFFFF 00000001 003120B3 00000001 00000404 00000009
00000404 FFFFFFFF 00000001 003130B3 00000000 00000408 00000009
00000600 F0F0F0F0 0FF00FF0 003140B3 FF00FF00 00000604 00000009
00000700 00000010 00000000 FFF10093 0000000F 00000704 00000009
00000704 80001234 DEADBEEF 40815093 FF800012 00000708 00000009
00000708 00000000 00000005 00113093 00000001 0000070C 00000009
00001000 00000005 00000005 00310863 00000000 00001010 00000003
00001000 00000005 00000006 00310863 00000000 00001004 00000001
00001000 00000005 00000006 FE311CE3 00000000 00000FF8 00000003
00001000 00000007 00000007 00311863 00000000 00001004 00000001
00001000 80000000 00000001 00314863 00000000 00001010 00000003
00001000 00000001 80000000 00314863 00000000 00001004 00000001
00001000 00000001 80000000 00315863 00000000 00001010 00000003
00001000 80000000 00000001 00315863 00000000 00001004 00000001
00001000 00000001 80000000 00316863 00000000 00001010 00000003
00001000 80000000 00000001 00316863 00000000 00001004 00000001
00001000 80000000 00000001 00317863 00000000 00001010 00000003
00001000 00000001 80000000 00317863 00000000 00001004 00000001
00002000 00000000 00000000 100000EF 00002004 00002100 0000000B
00002200 00003000 00000000 003100E7 00002204 00003002 0000000B
00002300 00000000 00000000 ABCDE0B7 ABCDE000 00002304 00000009
00002400 00000000 00000000 00001097 00003400 00002404 00000009
00002500 00000010 00000000 00012083 00000000 00002504 00000005
00002600 00000003 00000004 023100B3 00000000 00002604 00000005

//--- testbench/tb_exec_top.sv
`timescale 1ns/1ps

module tb_exec_top import rv_exec_pkg::*; ();

    localparam int N_PAT       = 27;
    localparam int N_COL       = 7;
    localparam int CYCLE_LIMIT = 40 * N_PAT + 200;

    logic        pclk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] pat_mem [0:N_PAT*N_COL-1];
    int          errors = 0;
    int          cycles = 0;
    int unsigned seed;

    exec_top #(
        .APB_ADDR_WIDTH(12)
    ) DUT (
        .pclk(pclk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #10 pclk = ~pclk;

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ========================================================================
    // Checking and APB transfers
    // ========================================================================
    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic idle_cycles();
        int n;
        n = $urandom % 4;
        repeat (n) @(negedge pclk);
    endtask

    // Setup phase, then access phase sampled mid low phase
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        idle_cycles();
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge pclk);
        penable = 1'b1;
        #5;
        rdata = prdata;
        err   = pslverr;
        compare_word("pready", {31'd0, pready}, 32'd1);
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        compare_word($sformatf("pslverr write 0x%03h", addr), {31'd0, err}, {31'd0, exp_err});
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
                              input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        compare_word(name, rdata, exp_data);
        compare_word({name, " pslverr"}, {31'd0, err}, {31'd0, exp_err});
    endtask

    // ========================================================================
    // Test sequences
    // ========================================================================
    task automatic run_pattern(input int idx);
        int    base;
        string tag;
        base = idx * N_COL;
        tag  = $sformatf("pattern %0d", idx);
        apb_write(12'(REG_PC), pat_mem[base], 1'b0);
        apb_write(12'(REG_RS1), pat_mem[base+1], 1'b0);
        apb_write(12'(REG_RS2), pat_mem[base+2], 1'b0);
        // Launches the execution
        apb_write(12'(REG_INSN), pat_mem[base+3], 1'b0);
        read_check({tag, " rd"}, 12'(REG_RD), pat_mem[base+4], 1'b0);
        read_check({tag, " next_pc"}, 12'(REG_NEXT_PC), pat_mem[base+5], 1'b0);
        read_check({tag, " status"}, 12'(REG_STATUS), pat_mem[base+6], 1'b0);
    endtask

    task automatic check_bad_accesses();
        int last;
        last = (N_PAT - 1) * N_COL;
        // Read-only register
        apb_write(12'(REG_STATUS), 32'hFFFF_FFFF, 1'b1);
        read_check("status after write", 12'(REG_STATUS), pat_mem[last+6], 1'b0);
        // Unmapped offset
        apb_write(12'(REG_PC), 32'h0000_0ABC, 1'b0);
        apb_write(12'h020, 32'h1234_5678, 1'b1);
        read_check("pc after unmapped write", 12'(REG_PC), 32'h0000_0ABC, 1'b0);
        read_check("unmapped read", 12'h020, 32'd0, 1'b1);
        // Unaligned address next to RS1
        apb_write(12'h005, 32'hFFFF_FFFF, 1'b1);
        read_check("rs1 after unaligned write", 12'(REG_RS1), pat_mem[last+1], 1'b0);
    endtask

    initial begin
        seed    = $urandom(80507);
        pclk    = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 12'd0;
        pwdata  = 32'd0;
        $readmemh("testbench/exec_patterns.hex", pat_mem);

        repeat (16) @(negedge pclk);
        rst = 1'b0;

        read_check("reset rd", 12'(REG_RD), 32'd0, 1'b0);
        read_check("reset next_pc", 12'(REG_NEXT_PC), 32'd0, 1'b0);
        read_check("reset status", 12'(REG_STATUS), 32'd0, 1'b0);

        for (int i = 0; i < N_PAT; i++) begin
            run_pattern(i);
        end

        check_bad_accesses();

        $display("Summary: %0d patterns, %0d errors", N_PAT, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
